/* design/usb4_li_params.svh */
`ifndef USB4_LI_PARAMS_SVH
`define USB4_LI_PARAMS_SVH

// Cable descriptor in config space
`define LI_CABLE_ADDR        8'd18
`define LI_USB4_BYTE         8'h40
`define LI_CABLE_GEN4_BIT    21
`define LI_CABLE_GEN3_BIT    20

// Partner generation bits in the AT payload
`define LI_PARTNER_GEN4_BIT  18
`define LI_PARTNER_GEN3_BIT  13

// Generation codes, a slower link has a higher code
`define LI_GEN4              2'd0
`define LI_GEN3              2'd1
`define LI_GEN2              2'd2

// Transaction select codes
`define LI_TRANS_IDLE        3'd0
`define LI_TRANS_AT          3'd2

// Lane data select, received ordered sets carry the same codes
`define LI_DSEL_SLOS1        4'd0
`define LI_DSEL_SLOS2        4'd1
`define LI_DSEL_TS1_GEN3     4'd2
`define LI_DSEL_TS2_GEN3     4'd3
`define LI_DSEL_TS1_GEN4     4'd4
`define LI_DSEL_TS2_GEN4     4'd5
`define LI_DSEL_TS3_GEN4     4'd6
`define LI_DSEL_TS4_GEN4     4'd7
`define LI_DSEL_CL0          4'd8
`define LI_DSEL_ZEROS        4'd9

// Ordered-set count targets
`define LI_SENT_GEN4         6'd16
`define LI_RECV_GEN4         6'd1
`define LI_SENT_SLOS         6'd2
`define LI_RECV_GEN3         6'd2
`define LI_SENT_TS1_GEN3     6'd16
`define LI_SENT_TS1_GEN2     6'd32
`define LI_SENT_TS2_GEN3     6'd8
`define LI_SENT_TS2_GEN2     6'd16

`endif

/* design/usb4_li_pkg.sv */
`include "usb4_li_params.svh"

package usb4_li_pkg;

    typedef enum logic [3:0] {
        DISABLED       = 4'd0,
        CLD_CABLE      = 4'd1,
        CLD_DETECT     = 4'd2,
        CLD_EXCHANGE_1 = 4'd3,
        CLD_EXCHANGE_2 = 4'd4,
        CLD_CLOCK      = 4'd5,
        TS1_GEN4       = 4'd6,
        TS2_GEN4       = 4'd7,
        TS3_GEN4       = 4'd8,
        TS4_GEN4       = 4'd9,
        SLOS1_GEN3     = 4'd10,
        SLOS2_GEN3     = 4'd11,
        TS1_GEN3       = 4'd12,
        TS2_GEN3       = 4'd13,
        CL0            = 4'd14
    } li_state_e;

    typedef logic [1:0] gen_t;
    typedef logic [3:0] dsel_t;
    typedef logic [3:0] os_code_t;
    typedef logic [5:0] os_cnt_t;
    typedef logic [2:0] trans_sel_t;

    // Lane code of a state, also the code expected back from the partner
    function automatic dsel_t state_dsel(input li_state_e s);
        case (s)
            SLOS1_GEN3: return `LI_DSEL_SLOS1;
            SLOS2_GEN3: return `LI_DSEL_SLOS2;
            TS1_GEN3:   return `LI_DSEL_TS1_GEN3;
            TS2_GEN3:   return `LI_DSEL_TS2_GEN3;
            TS1_GEN4:   return `LI_DSEL_TS1_GEN4;
            TS2_GEN4:   return `LI_DSEL_TS2_GEN4;
            TS3_GEN4:   return `LI_DSEL_TS3_GEN4;
            TS4_GEN4:   return `LI_DSEL_TS4_GEN4;
            CL0:        return `LI_DSEL_CL0;
            default:    return `LI_DSEL_ZEROS;
        endcase
    endfunction

endpackage

/* design/link_params_if.sv */
`timescale 1ns/1ps

// Negotiated link parameters shared by the probe, negotiator, FSM and counter
interface link_params_if;

    logic              cable_usb4;
    usb4_li_pkg::gen_t cable_gen;
    usb4_li_pkg::gen_t partner_gen;
    usb4_li_pkg::gen_t link_speed;

    modport probe (
        output cable_usb4,
        output cable_gen
    );

    modport negotiator (
        input  cable_gen,
        output partner_gen,
        output link_speed
    );

    modport ctrl (
        input cable_usb4,
        input link_speed
    );

    modport counter (
        input link_speed
    );

endinterface

/* design/lane_init_ctrl.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module lane_init_ctrl (
    input  logic                   fsm_clk,
    input  logic                   reset_n,
    input  logic                   lane_disable_i,
    input  logic                   tdisabled_min_i,
    input  logic                   disconnect_sbrx_i,
    input  logic                   t_valid_i,
    input  logic                   trans_error_i,
    input  logic                   trans_sent_i,
    input  logic                   new_sym_i,
    input  logic                   ttraining_error_timeout_i,
    input  logic                   targets_met_i,
    link_params_if.ctrl            lp,
    output usb4_li_pkg::li_state_e state_o,
    output usb4_li_pkg::dsel_t     d_sel_o,
    output logic                   fsm_disabled_o,
    output logic                   fsm_training_o
);

    usb4_li_pkg::li_state_e state_q;
    usb4_li_pkg::li_state_e next_state;

    function automatic logic is_training(input usb4_li_pkg::li_state_e s);
        return s inside {usb4_li_pkg::TS1_GEN4, usb4_li_pkg::TS2_GEN4,
                         usb4_li_pkg::TS3_GEN4, usb4_li_pkg::TS4_GEN4,
                         usb4_li_pkg::SLOS1_GEN3, usb4_li_pkg::SLOS2_GEN3,
                         usb4_li_pkg::TS1_GEN3, usb4_li_pkg::TS2_GEN3};
    endfunction

    // States past detect where a sideband disconnect restarts detection
    function automatic logic sbrx_abort(input usb4_li_pkg::li_state_e s);
        return is_training(s) || s inside {usb4_li_pkg::CLD_EXCHANGE_1,
                                           usb4_li_pkg::CLD_EXCHANGE_2,
                                           usb4_li_pkg::CL0};
    endfunction

    assign state_o = state_q;

    always_comb begin
        next_state = state_q;
        case (state_q)
            usb4_li_pkg::DISABLED:
                if (tdisabled_min_i)
                    next_state = usb4_li_pkg::CLD_CABLE;
            usb4_li_pkg::CLD_CABLE:
                if (lp.cable_usb4)
                    next_state = usb4_li_pkg::CLD_DETECT;
            usb4_li_pkg::CLD_DETECT:
                if (!disconnect_sbrx_i)
                    next_state = usb4_li_pkg::CLD_EXCHANGE_1;
            usb4_li_pkg::CLD_EXCHANGE_1:
                if (t_valid_i && !trans_error_i)
                    next_state = usb4_li_pkg::CLD_EXCHANGE_2;
            usb4_li_pkg::CLD_EXCHANGE_2:
                if (trans_sent_i)
                    next_state = usb4_li_pkg::CLD_CLOCK;
            usb4_li_pkg::CLD_CLOCK: begin
                // Gen4 trains with TS1..TS4, slower links start with SLOS
                if (new_sym_i && lp.link_speed == `LI_GEN4)
                    next_state = usb4_li_pkg::TS1_GEN4;
                else if (new_sym_i)
                    next_state = usb4_li_pkg::SLOS1_GEN3;
            end
            usb4_li_pkg::TS1_GEN4:
                if (targets_met_i)
                    next_state = usb4_li_pkg::TS2_GEN4;
            usb4_li_pkg::TS2_GEN4:
                if (targets_met_i)
                    next_state = usb4_li_pkg::TS3_GEN4;
            usb4_li_pkg::TS3_GEN4:
                if (targets_met_i)
                    next_state = usb4_li_pkg::TS4_GEN4;
            usb4_li_pkg::SLOS1_GEN3:
                if (targets_met_i)
                    next_state = usb4_li_pkg::SLOS2_GEN3;
            usb4_li_pkg::SLOS2_GEN3:
                if (targets_met_i)
                    next_state = usb4_li_pkg::TS1_GEN3;
            usb4_li_pkg::TS1_GEN3:
                if (targets_met_i)
                    next_state = usb4_li_pkg::TS2_GEN3;
            // Last training state waits for a symbol boundary
            usb4_li_pkg::TS4_GEN4, usb4_li_pkg::TS2_GEN3:
                if (targets_met_i && new_sym_i)
                    next_state = usb4_li_pkg::CL0;
            usb4_li_pkg::CL0:
                next_state = usb4_li_pkg::CL0;
            default:
                next_state = usb4_li_pkg::DISABLED;
        endcase

        // Abort paths, later checks win
        if (is_training(state_q) && ttraining_error_timeout_i)
            next_state = usb4_li_pkg::CLD_EXCHANGE_1;
        if (sbrx_abort(state_q) && disconnect_sbrx_i)
            next_state = usb4_li_pkg::CLD_DETECT;
        if (lane_disable_i)
            next_state = usb4_li_pkg::DISABLED;
    end

    // Outputs follow the next state so they move with the state register
    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q        <= usb4_li_pkg::DISABLED;
            d_sel_o        <= `LI_DSEL_ZEROS;
            fsm_disabled_o <= 1'b1;
            fsm_training_o <= 1'b0;
        end else begin
            state_q        <= next_state;
            d_sel_o        <= usb4_li_pkg::state_dsel(next_state);
            fsm_disabled_o <= (next_state == usb4_li_pkg::DISABLED);
            fsm_training_o <= is_training(next_state);
        end
    end

endmodule

/* design/cable_probe.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module cable_probe (
    input  logic                   fsm_clk,
    input  logic                   reset_n,
    input  usb4_li_pkg::li_state_e state_i,
    input  logic [31:0]            c_data_i,
    output logic                   c_read_o,
    output logic [7:0]             c_address_o,
    link_params_if.probe           lp
);

    // Descriptor read runs for as long as the FSM sits in CLD_CABLE
    assign c_read_o    = (state_i == usb4_li_pkg::CLD_CABLE);
    assign c_address_o = c_read_o ? `LI_CABLE_ADDR : 8'd0;

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            lp.cable_usb4 <= 1'b0;
            lp.cable_gen  <= `LI_GEN4;
        end else if (state_i == usb4_li_pkg::DISABLED) begin
            lp.cable_usb4 <= 1'b0;
            lp.cable_gen  <= `LI_GEN4;
        end else if (c_read_o) begin
            lp.cable_usb4 <= (c_data_i[7:0] == `LI_USB4_BYTE);
            // Gen4 bit wins over Gen3, neither means Gen2
            if (c_data_i[`LI_CABLE_GEN4_BIT])
                lp.cable_gen <= `LI_GEN4;
            else if (c_data_i[`LI_CABLE_GEN3_BIT])
                lp.cable_gen <= `LI_GEN3;
            else
                lp.cable_gen <= `LI_GEN2;
        end
    end

endmodule

/* design/gen_negotiator.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module gen_negotiator (
    input  logic                   fsm_clk,
    input  logic                   reset_n,
    input  usb4_li_pkg::li_state_e state_i,
    input  logic                   t_valid_i,
    input  logic [23:0]            payload_i,
    link_params_if.negotiator      lp
);

    usb4_li_pkg::gen_t payload_gen;
    logic              capture;

    assign payload_gen = payload_i[`LI_PARTNER_GEN4_BIT] ? `LI_GEN4 :
                         payload_i[`LI_PARTNER_GEN3_BIT] ? `LI_GEN3 : `LI_GEN2;

    assign capture = t_valid_i && (state_i == usb4_li_pkg::CLD_EXCHANGE_1);

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            lp.partner_gen <= `LI_GEN4;
            lp.link_speed  <= `LI_GEN4;
        end else if (state_i == usb4_li_pkg::DISABLED) begin
            lp.partner_gen <= `LI_GEN4;
            lp.link_speed  <= `LI_GEN4;
        end else begin
            if (capture)
                lp.partner_gen <= payload_gen;
            // Slower side sets the speed, so Gen2 beats Gen3 beats Gen4
            if (lp.cable_gen == `LI_GEN2 || lp.partner_gen == `LI_GEN2)
                lp.link_speed <= `LI_GEN2;
            else if (lp.cable_gen == `LI_GEN3 || lp.partner_gen == `LI_GEN3)
                lp.link_speed <= `LI_GEN3;
            else
                lp.link_speed <= `LI_GEN4;
        end
    end

endmodule

/* design/os_counter.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module os_counter (
    input  logic                   fsm_clk,
    input  logic                   reset_n,
    input  usb4_li_pkg::li_state_e state_i,
    input  logic                   os_sent_i,
    input  usb4_li_pkg::os_code_t  os_in_l0_i,
    input  usb4_li_pkg::os_code_t  os_in_l1_i,
    link_params_if.counter         lp,
    output logic                   targets_met_o
);

    usb4_li_pkg::li_state_e prev_state_q;
    usb4_li_pkg::os_code_t  exp_code;
    usb4_li_pkg::os_cnt_t   sent_tgt;
    usb4_li_pkg::os_cnt_t   recv_tgt;
    usb4_li_pkg::os_cnt_t   sent_cnt_q;
    usb4_li_pkg::os_cnt_t   l0_cnt_q;
    usb4_li_pkg::os_cnt_t   l1_cnt_q;
    logic                   entry;
    logic                   gen2;

    assign entry    = (state_i != prev_state_q);
    assign gen2     = (lp.link_speed == `LI_GEN2);
    assign exp_code = usb4_li_pkg::state_dsel(state_i);

    // Targets stay zero outside training
    always_comb begin
        sent_tgt = '0;
        recv_tgt = '0;
        case (state_i)
            usb4_li_pkg::TS1_GEN4, usb4_li_pkg::TS2_GEN4,
            usb4_li_pkg::TS3_GEN4, usb4_li_pkg::TS4_GEN4: begin
                sent_tgt = `LI_SENT_GEN4;
                recv_tgt = `LI_RECV_GEN4;
            end
            usb4_li_pkg::SLOS1_GEN3, usb4_li_pkg::SLOS2_GEN3: begin
                sent_tgt = `LI_SENT_SLOS;
                recv_tgt = `LI_RECV_GEN3;
            end
            usb4_li_pkg::TS1_GEN3: begin
                sent_tgt = gen2 ? `LI_SENT_TS1_GEN2 : `LI_SENT_TS1_GEN3;
                recv_tgt = `LI_RECV_GEN3;
            end
            usb4_li_pkg::TS2_GEN3: begin
                sent_tgt = gen2 ? `LI_SENT_TS2_GEN2 : `LI_SENT_TS2_GEN3;
                recv_tgt = `LI_RECV_GEN3;
            end
            default: begin
                sent_tgt = '0;
                recv_tgt = '0;
            end
        endcase
    end

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_state_q <= usb4_li_pkg::DISABLED;
            sent_cnt_q   <= '0;
            l0_cnt_q     <= '0;
            l1_cnt_q     <= '0;
        end else begin
            prev_state_q <= state_i;
            if (entry) begin
                sent_cnt_q <= '0;
                l0_cnt_q   <= '0;
                l1_cnt_q   <= '0;
            end else begin
                if (os_sent_i && sent_cnt_q < sent_tgt)
                    sent_cnt_q <= sent_cnt_q + 6'd1;
                if (os_in_l0_i == exp_code && l0_cnt_q < recv_tgt)
                    l0_cnt_q <= l0_cnt_q + 6'd1;
                if (os_in_l1_i == exp_code && l1_cnt_q < recv_tgt)
                    l1_cnt_q <= l1_cnt_q + 6'd1;
            end
        end
    end

    // Counts left from the previous state are ignored on entry
    assign targets_met_o = !entry && (sent_cnt_q == sent_tgt) &&
                           (l0_cnt_q == recv_tgt) && (l1_cnt_q == recv_tgt);

endmodule

/* design/sb_trans_ctrl.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module sb_trans_ctrl (
    input  logic                    fsm_clk,
    input  logic                    reset_n,
    input  usb4_li_pkg::li_state_e  state_i,
    input  logic                    sync_busy_i,
    input  logic                    trans_error_i,
    output usb4_li_pkg::trans_sel_t trans_sel_o,
    output logic                    disconnect_sbtx_o
);

    logic in_ex1;
    logic in_ex1_q;
    logic at_pend_q;
    logic at_req;
    logic at_fire;

    assign in_ex1  = (state_i == usb4_li_pkg::CLD_EXCHANGE_1);
    // Request is raised on entry or left pending by an error or a busy sideband
    assign at_req  = in_ex1 && (at_pend_q || !in_ex1_q);
    assign at_fire = at_req && !sync_busy_i;

    assign trans_sel_o = at_fire ? `LI_TRANS_AT : `LI_TRANS_IDLE;

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            in_ex1_q          <= 1'b0;
            at_pend_q         <= 1'b0;
            disconnect_sbtx_o <= 1'b1;
        end else begin
            in_ex1_q  <= in_ex1;
            at_pend_q <= in_ex1 && (trans_error_i || (at_req && !at_fire));
            // Sideband transmitter stays off until the cable is found
            disconnect_sbtx_o <= (state_i == usb4_li_pkg::DISABLED) ||
                                 (state_i == usb4_li_pkg::CLD_CABLE);
        end
    end

endmodule

/* design/usb4_lane_init_top.sv */
`timescale 1ns/1ps

module usb4_lane_init_top (
    input  logic                    fsm_clk,
    input  logic                    reset_n,
    input  logic                    lane_disable_i,
    input  logic                    tdisabled_min_i,
    input  logic [31:0]             c_data_i,
    input  logic                    disconnect_sbrx_i,
    input  logic                    sync_busy_i,
    input  logic                    t_valid_i,
    input  logic                    trans_error_i,
    input  logic                    trans_sent_i,
    input  logic [23:0]             payload_i,
    input  logic                    new_sym_i,
    input  logic                    os_sent_i,
    input  usb4_li_pkg::os_code_t   os_in_l0_i,
    input  usb4_li_pkg::os_code_t   os_in_l1_i,
    input  logic                    ttraining_error_timeout_i,
    output usb4_li_pkg::dsel_t      d_sel_o,
    output usb4_li_pkg::gen_t       link_speed_o,
    output logic [7:0]              c_address_o,
    output logic                    c_read_o,
    output usb4_li_pkg::trans_sel_t trans_sel_o,
    output logic                    disconnect_sbtx_o,
    output logic                    fsm_disabled_o,
    output logic                    fsm_training_o
);

    usb4_li_pkg::li_state_e li_state;
    logic                   targets_met;

    link_params_if lp ();

    assign link_speed_o = lp.link_speed;

    lane_init_ctrl u_ctrl (
        .fsm_clk                   (fsm_clk),
        .reset_n                   (reset_n),
        .lane_disable_i            (lane_disable_i),
        .tdisabled_min_i           (tdisabled_min_i),
        .disconnect_sbrx_i         (disconnect_sbrx_i),
        .t_valid_i                 (t_valid_i),
        .trans_error_i             (trans_error_i),
        .trans_sent_i              (trans_sent_i),
        .new_sym_i                 (new_sym_i),
        .ttraining_error_timeout_i (ttraining_error_timeout_i),
        .targets_met_i             (targets_met),
        .lp                        (lp.ctrl),
        .state_o                   (li_state),
        .d_sel_o                   (d_sel_o),
        .fsm_disabled_o            (fsm_disabled_o),
        .fsm_training_o            (fsm_training_o)
    );

    cable_probe u_probe (
        .fsm_clk     (fsm_clk),
        .reset_n     (reset_n),
        .state_i     (li_state),
        .c_data_i    (c_data_i),
        .c_read_o    (c_read_o),
        .c_address_o (c_address_o),
        .lp          (lp.probe)
    );

    gen_negotiator u_negotiator (
        .fsm_clk   (fsm_clk),
        .reset_n   (reset_n),
        .state_i   (li_state),
        .t_valid_i (t_valid_i),
        .payload_i (payload_i),
        .lp        (lp.negotiator)
    );

    os_counter u_os_counter (
        .fsm_clk       (fsm_clk),
        .reset_n       (reset_n),
        .state_i       (li_state),
        .os_sent_i     (os_sent_i),
        .os_in_l0_i    (os_in_l0_i),
        .os_in_l1_i    (os_in_l1_i),
        .lp            (lp.counter),
        .targets_met_o (targets_met)
    );

    sb_trans_ctrl u_sb_trans (
        .fsm_clk           (fsm_clk),
        .reset_n           (reset_n),
        .state_i           (li_state),
        .sync_busy_i       (sync_busy_i),
        .trans_error_i     (trans_error_i),
        .trans_sel_o       (trans_sel_o),
        .disconnect_sbtx_o (disconnect_sbtx_o)
    );

endmodule

/* verification/usb4_lane_init_assertions.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module usb4_lane_init_assertions (
    input logic       fsm_clk,
    input logic       reset_n,
    input logic       lane_disable_i,
    input logic       sync_busy_i,
    input logic       ttraining_error_timeout_i,
    input logic [3:0] d_sel_o,
    input logic [1:0] link_speed_o,
    input logic [7:0] c_address_o,
    input logic       c_read_o,
    input logic [2:0] trans_sel_o,
    input logic       disconnect_sbtx_o,
    input logic       fsm_disabled_o,
    input logic       fsm_training_o
);

    int fail_count = 0;

    // Both training orders end in the CL0 code
    function automatic logic [3:0] next_dsel(input logic [3:0] prev);
        if (prev == `LI_DSEL_TS2_GEN3 || prev == `LI_DSEL_TS4_GEN4)
            return `LI_DSEL_CL0;
        return prev + 4'd1;
    endfunction

    reset_values: assert property (@(posedge fsm_clk)
        $rose(reset_n) |-> fsm_disabled_o && !fsm_training_o && !c_read_o &&
        d_sel_o == `LI_DSEL_ZEROS && trans_sel_o == `LI_TRANS_IDLE && disconnect_sbtx_o)
        else begin
            $error("outputs not at reset values after reset");
            fail_count++;
        end

    cable_read: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        $fell(fsm_disabled_o) |-> c_read_o && c_address_o == `LI_CABLE_ADDR)
        else begin
            $error("cable descriptor not read at its address after leaving disabled");
            fail_count++;
        end

    at_single_cycle: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        trans_sel_o == `LI_TRANS_AT |=> trans_sel_o != `LI_TRANS_AT)
        else begin
            $error("AT strobe longer than one cycle");
            fail_count++;
        end

    at_allowed: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        trans_sel_o == `LI_TRANS_AT |-> !sync_busy_i && !disconnect_sbtx_o)
        else begin
            $error("AT strobe while sideband busy or disconnected");
            fail_count++;
        end

    training_entry: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        $rose(fsm_training_o) |->
        d_sel_o == ((link_speed_o == `LI_GEN4) ? `LI_DSEL_TS1_GEN4 : `LI_DSEL_SLOS1))
        else begin
            $error("training started with the wrong lane code");
            fail_count++;
        end

    training_order: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        $past(fsm_training_o) && d_sel_o != $past(d_sel_o) |->
        d_sel_o == `LI_DSEL_ZEROS || d_sel_o == next_dsel($past(d_sel_o)))
        else begin
            $error("lane code left the training order");
            fail_count++;
        end

    lane_disable: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        lane_disable_i |=> (fsm_disabled_o && d_sel_o == `LI_DSEL_ZEROS) ##1 disconnect_sbtx_o)
        else begin
            $error("lane disable not honoured");
            fail_count++;
        end

    training_timeout: assert property (@(posedge fsm_clk) disable iff (!reset_n)
        fsm_training_o && ttraining_error_timeout_i && !lane_disable_i |=>
        !fsm_training_o && trans_sel_o == `LI_TRANS_AT)
        else begin
            $error("training timeout did not restart the exchange");
            fail_count++;
        end

endmodule

/* verification/tb_usb4_lane_init.sv */
`timescale 1ns/1ps
`include "usb4_li_params.svh"

module tb_usb4_lane_init;

    logic        fsm_clk = 1'b0;
    logic        reset_n;
    logic        lane_disable_i, tdisabled_min_i, disconnect_sbrx_i, sync_busy_i;
    logic        t_valid_i, trans_error_i, trans_sent_i, new_sym_i, os_sent_i;
    logic        ttraining_error_timeout_i;
    logic [31:0] c_data_i;
    logic [23:0] payload_i;
    logic [3:0]  os_in_l0_i, os_in_l1_i, d_sel_o;
    logic [1:0]  link_speed_o, exp_speed;
    logic [7:0]  c_address_o;
    logic [2:0]  trans_sel_o;
    logic        c_read_o, disconnect_sbtx_o, fsm_disabled_o, fsm_training_o;
    logic [31:0] rnd = 32'd73184;
    logic        training_q = 1'b0;
    logic        sent_next = 1'b0;
    logic        at_seen = 1'b0;
    int          at_wait = 0;
    int          cycles = 0;
    int          errors = 0;
    string       test_name = "reset";

    usb4_lane_init_top dut_i (.*);

    bind usb4_lane_init_top usb4_lane_init_assertions u_assert (.*);

    always #4 fsm_clk = ~fsm_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Higher code is the slower generation
    function automatic logic [1:0] slower_gen(input logic [1:0] a, input logic [1:0] b);
        return (a > b) ? a : b;
    endfunction

    // AT strobe as it stood just before the clock edge
    always @(posedge fsm_clk) begin
        at_seen <= (trans_sel_o == `LI_TRANS_AT);
    end

    // Partner model answering AT strobes and echoing the training ordered sets
    always @(negedge fsm_clk) begin
        if (reset_n) begin
            rnd = xorshift(rnd);
            t_valid_i    = 1'b0;
            trans_sent_i = sent_next;
            sent_next    = 1'b0;
            if (at_seen) begin
                at_wait = 2 + int'(rnd[1:0]);
            end else if (at_wait > 0) begin
                at_wait = at_wait - 1;
                if (at_wait == 0) begin
                    t_valid_i = 1'b1;
                    sent_next = 1'b1;
                end
            end
            os_sent_i  = fsm_training_o && rnd[2];
            os_in_l0_i = fsm_training_o ? d_sel_o : `LI_DSEL_ZEROS;
            os_in_l1_i = fsm_training_o ? d_sel_o : `LI_DSEL_ZEROS;
            new_sym_i  = (rnd[5:4] == 2'd0);
        end
    end

    // Link speed seen at the start of training
    always @(negedge fsm_clk) begin
        if (fsm_training_o && !training_q && link_speed_o !== exp_speed) begin
            $display("MISMATCH %s link_speed expected %0d actual %0d",
                     test_name, exp_speed, link_speed_o);
            errors++;
        end
        training_q <= fsm_training_o;
    end

    always @(posedge fsm_clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("timeout after %0d cycles, controller never reached CL0", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic restart_link();
        @(negedge fsm_clk);
        lane_disable_i = 1'b1;
        @(negedge fsm_clk);
        lane_disable_i = 1'b0;
    endtask

    task automatic wait_cl0();
        while (d_sel_o != `LI_DSEL_CL0)
            @(negedge fsm_clk);
        repeat (4) @(negedge fsm_clk);
    endtask

    // Cable gen 0 sets bit 21, gen 1 bit 20, partner gen 0 bit 18, gen 1 bit 13
    task automatic run_link(input string name, input logic [1:0] cable,
                            input logic [1:0] partner, input logic with_timeout);
        test_name = name;
        c_data_i  = {10'd0, cable == 2'd0, cable == 2'd1, 12'd0, 8'h40};
        payload_i = {5'd0, partner == 2'd0, 4'd0, partner == 2'd1, 13'd0};
        exp_speed = slower_gen(cable, partner);
        // Sideband stays busy into CLD_EXCHANGE_1 so the AT strobe has to wait
        sync_busy_i = 1'b1;
        while (!c_read_o)
            @(negedge fsm_clk);
        while (disconnect_sbtx_o)
            @(negedge fsm_clk);
        repeat (2) @(negedge fsm_clk);
        sync_busy_i = 1'b0;
        if (with_timeout) begin
            while (!fsm_training_o)
                @(negedge fsm_clk);
            repeat (3) @(negedge fsm_clk);
            ttraining_error_timeout_i = 1'b1;
            @(negedge fsm_clk);
            ttraining_error_timeout_i = 1'b0;
        end
        wait_cl0();
    endtask

    initial begin
        reset_n = 1'b0;
        lane_disable_i = 1'b0;
        tdisabled_min_i = 1'b1;
        disconnect_sbrx_i = 1'b0;
        sync_busy_i = 1'b0;
        t_valid_i = 1'b0;
        trans_error_i = 1'b0;
        trans_sent_i = 1'b0;
        new_sym_i = 1'b0;
        os_sent_i = 1'b0;
        ttraining_error_timeout_i = 1'b0;
        c_data_i = 32'd0;
        payload_i = 24'd0;
        os_in_l0_i = `LI_DSEL_ZEROS;
        os_in_l1_i = `LI_DSEL_ZEROS;
        exp_speed = `LI_GEN4;
        repeat (2) @(negedge fsm_clk);
        reset_n = 1'b1;
        run_link("gen4_cable_gen4_partner", `LI_GEN4, `LI_GEN4, 1'b0);
        restart_link();
        run_link("gen4_cable_gen3_partner", `LI_GEN4, `LI_GEN3, 1'b0);
        restart_link();
        run_link("gen3_cable_gen2_partner", `LI_GEN3, `LI_GEN2, 1'b0);
        restart_link();
        run_link("training_timeout", `LI_GEN4, `LI_GEN3, 1'b1);
        // Disable from CL0 then train once more
        restart_link();
        run_link("disable_in_cl0", `LI_GEN4, `LI_GEN4, 1'b1);
        $display("errors: checks=%0d assertions=%0d", errors, dut_i.u_assert.fail_count);
        if (errors == 0 && dut_i.u_assert.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* usb4_lane_init.f */
+incdir+design
design/usb4_li_pkg.sv
design/link_params_if.sv
design/lane_init_ctrl.sv
design/cable_probe.sv
design/gen_negotiator.sv
design/os_counter.sv
design/sb_trans_ctrl.sv
design/usb4_lane_init_top.sv
verification/usb4_lane_init_assertions.sv
verification/tb_usb4_lane_init.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the lane init testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f usb4_lane_init.f \
    --top-module tb_usb4_lane_init -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_usb4_lane_init > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
